// File: files.f
+incdir+hw
hw/flash_mubi_pkg.sv
hw/flash_prot_pkg.sv
hw/flash_page_cfg_regs.sv
hw/flash_info_cfg.sv
hw/flash_access_check.sv
hw/flash_prot_ctrl.sv
hw/flash_prot_top.sv
bench/flash_prot_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator and runs it
# the result is taken from the log, not from the simulator exit status
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --timescale 1ns/1ps \
  --top-module flash_prot_tb \
  --Mdir obj_dir \
  -o flash_prot_sim \
  -f files.f

./obj_dir/flash_prot_sim | tee sim.log

if grep -qx "Test OK" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see sim.log"
  exit 1
fi

// File: bench/flash_prot_tb.sv
// testbench for the info page protection unit
// the reference model keeps its own copy of every written page config as plain bits
// privileges change only through a task that waits four cycles, so the model can use
// the current privilege values when it predicts a response
// responses are predicted when a request is driven and compared when done pulses
// the run stops at the first mismatch

`default_nettype none

`include "flash_prot_macros.svh"

module flash_prot_tb import flash_mubi_pkg::*; import flash_prot_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int table_len = 24;
  localparam int sweep_len = 400;
  localparam int sat_len = 300;
  // ten clock cycles of 10 ns for every table row and every random or saturation step
  localparam int watchdog_ns = (table_len + sweep_len + sat_len) * 10 * 10;

  // decoded page permissions as the model sees them
  typedef struct packed {
    logic en;
    logic rd;
    logic prog;
    logic erase;
    logic scr;
    logic ecc;
    logic he;
  } perm_t;

  // priv holds creator, owner, isolation read and isolation write from msb down
  typedef struct packed {
    logic [3:0] priv;
    flash_op_e op;
    page_addr_t addr;
    flash_resp_t want;
  } vec_t;

  // addr is bank_infosel_page, want is granted scramble ecc he
  localparam vec_t vec_tbl [table_len] = '{
    '{4'b0000, flash_op_read, 4'b0_0_00, 4'b1101},
    '{4'b0000, flash_op_prog, 4'b0_0_00, 4'b0000},
    '{4'b0000, flash_op_erase, 4'b0_0_00, 4'b1101},
    '{4'b0000, flash_op_read, 4'b1_1_01, 4'b0000},
    '{4'b0000, flash_op_prog, 4'b1_1_01, 4'b1010},
    '{4'b0000, flash_op_read, 4'b0_1_00, 4'b0000},
    '{4'b0000, flash_op_read, 4'b0_0_01, 4'b0000},
    '{4'b0000, flash_op_prog, 4'b0_0_10, 4'b0000},
    '{4'b1000, flash_op_read, 4'b0_0_01, 4'b1111},
    '{4'b1000, flash_op_erase, 4'b0_0_01, 4'b1111},
    '{4'b1000, flash_op_read, 4'b0_0_10, 4'b0000},
    '{4'b0100, flash_op_prog, 4'b0_0_10, 4'b1010},
    '{4'b0100, flash_op_erase, 4'b0_0_10, 4'b0000},
    '{4'b0100, flash_op_read, 4'b0_0_01, 4'b0000},
    '{4'b0000, flash_op_read, 4'b0_0_11, 4'b0000},
    '{4'b0010, flash_op_read, 4'b0_0_11, 4'b1100},
    '{4'b0010, flash_op_prog, 4'b0_0_11, 4'b0000},
    '{4'b0001, flash_op_prog, 4'b0_0_11, 4'b1100},
    '{4'b0011, flash_op_erase, 4'b0_0_11, 4'b0000},
    '{4'b1111, flash_op_read, 4'b1_1_10, 4'b0000},
    '{4'b1111, flash_op_erase, 4'b1_1_11, 4'b0000},
    '{4'b1111, flash_op_read, 4'b0_0_11, 4'b1100},
    '{4'b1111, flash_op_prog, 4'b0_0_01, 4'b1111},
    '{4'b1111, flash_op_erase, 4'b0_0_10, 4'b0000}
  };

  logic clk = 1'b0;
  logic arst_n = 1'b0;
  logic cfg_we = 1'b0;
  page_addr_t cfg_addr = '0;
  info_page_cfg_t cfg_wdata = '0;
  logic lock_set = 1'b0;
  logic creator_priv = 1'b0;
  logic owner_priv = 1'b0;
  logic iso_rd_en = 1'b0;
  logic iso_wr_en = 1'b0;
  logic req = 1'b0;
  flash_req_t req_data = '0;
  logic done;
  flash_resp_t resp;
  logic locked;
  logic [7:0] deny_cnt;

  perm_t model_cfg [`FLASH_BANKS][`FLASH_INFO_TYPES][`FLASH_INFOS_PER_BANK] = '{default: '0};
  logic model_locked = 1'b0;
  logic [7:0] model_deny = 8'd0;
  int neg_cnt = 0;
  flash_resp_t exp_q [$];
  int due_q [$];

  always #5 clk = ~clk;

  flash_prot_top dut0 (
    .clk_i(clk),
    .arst_n_i(arst_n),
    .cfg_we_i(cfg_we),
    .cfg_addr_i(cfg_addr),
    .cfg_wdata_i(cfg_wdata),
    .lock_set_i(lock_set),
    .creator_seed_priv_i(creator_priv),
    .owner_seed_priv_i(owner_priv),
    .iso_flash_rd_en_i(iso_rd_en),
    .iso_flash_wr_en_i(iso_wr_en),
    .req_i(req),
    .req_data_i(req_data),
    .done_o(done),
    .resp_o(resp),
    .locked_o(locked),
    .deny_cnt_o(deny_cnt)
  );

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      abort_run($sformatf("[FAIL] time %0t: %s is 0x%0h, expected 0x%0h",
                          $time, what, got, want));
    end
  endtask

  // bits are en, rd, prog, erase, scramble, ecc, he from msb down
  function automatic info_page_cfg_t encode_cfg(input logic [6:0] b);
    info_page_cfg_t c;
    c.en = b[6] ? mubi4_true : mubi4_false;
    c.rd_en = b[5] ? mubi4_true : mubi4_false;
    c.prog_en = b[4] ? mubi4_true : mubi4_false;
    c.erase_en = b[3] ? mubi4_true : mubi4_false;
    c.scramble_en = b[2] ? mubi4_true : mubi4_false;
    c.ecc_en = b[1] ? mubi4_true : mubi4_false;
    c.he_en = b[0] ? mubi4_true : mubi4_false;
    return c;
  endfunction

  // half the fields come out true, the rest false or an arbitrary 4-bit code
  function automatic mubi4_t pick_field(input logic [31:0] r);
    case (r[1:0])
      2'd0, 2'd1: return mubi4_true;
      2'd2: return mubi4_false;
      default: return r[7:4];
    endcase
  endfunction

  function automatic info_page_cfg_t random_cfg();
    info_page_cfg_t c;
    c.en = pick_field($urandom);
    c.rd_en = pick_field($urandom);
    c.prog_en = pick_field($urandom);
    c.erase_en = pick_field($urandom);
    c.scramble_en = pick_field($urandom);
    c.ecc_en = pick_field($urandom);
    c.he_en = pick_field($urandom);
    return c;
  endfunction

  function automatic flash_op_e pick_op(input logic [1:0] r);
    case (r)
      2'd1: return flash_op_prog;
      2'd2: return flash_op_erase;
      default: return flash_op_read;
    endcase
  endfunction

  // expected response from the stored permissions and the current privileges
  function automatic flash_resp_t predict(input flash_op_e op_v, input page_addr_t a);
    perm_t p;
    int size;
    logic allow;
    logic grant;
    flash_resp_t r;
    p = model_cfg[a.bank][a.info_sel][a.page];
    size = (int'(a.info_sel) == 0) ? `FLASH_INFO_TYPE0_SIZE : `FLASH_INFO_TYPE1_SIZE;
    // slots above the partition size do not exist
    if (int'(a.page) >= size) begin
      p = '0;
    end
    if (int'(a.bank) == `FLASH_SEED_BANK && int'(a.info_sel) == `FLASH_SEED_INFO_SEL) begin
      if (int'(a.page) == `FLASH_CREATOR_PAGE) begin
        p.en = p.en & creator_priv;
        p.rd = p.rd & creator_priv;
        p.prog = p.prog & creator_priv;
        p.erase = p.erase & creator_priv;
      end else if (int'(a.page) == `FLASH_OWNER_PAGE) begin
        p.en = p.en & owner_priv;
        p.rd = p.rd & owner_priv;
        p.prog = p.prog & owner_priv;
        p.erase = p.erase & owner_priv;
      end else if (int'(a.page) == `FLASH_ISOLATED_PAGE) begin
        p.rd = p.rd & iso_rd_en;
        p.prog = p.prog & iso_wr_en;
        p.erase = p.erase & iso_wr_en;
      end
    end
    case (op_v)
      flash_op_read: allow = p.rd;
      flash_op_prog: allow = p.prog;
      flash_op_erase: allow = p.erase;
      default: allow = 1'b0;
    endcase
    grant = p.en & allow;
    r.granted = grant;
    r.scramble = grant & p.scr;
    r.ecc = grant & p.ecc;
    r.he = grant & p.he;
    return r;
  endfunction

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      req <= 1'b0;
      cfg_we <= 1'b0;
      lock_set <= 1'b0;
    end
  endtask

  // the stored copy keeps only whether each field holds the exact true code
  task automatic store_model(input page_addr_t a, input info_page_cfg_t d);
    model_cfg[a.bank][a.info_sel][a.page] = '{
      en: d.en == mubi4_true,
      rd: d.rd_en == mubi4_true,
      prog: d.prog_en == mubi4_true,
      erase: d.erase_en == mubi4_true,
      scr: d.scramble_en == mubi4_true,
      ecc: d.ecc_en == mubi4_true,
      he: d.he_en == mubi4_true
    };
  endtask

  task automatic write_cfg(input page_addr_t a, input info_page_cfg_t d);
    @(posedge clk);
    req <= 1'b0;
    cfg_we <= 1'b1;
    cfg_addr <= a;
    cfg_wdata <= d;
    if (!model_locked) begin
      store_model(a, d);
    end
    idle(1);
  endtask

  // a write in the same cycle as the lock request still lands
  task automatic lock_with_write(input page_addr_t a, input info_page_cfg_t d);
    @(posedge clk);
    req <= 1'b0;
    cfg_we <= 1'b1;
    cfg_addr <= a;
    cfg_wdata <= d;
    lock_set <= 1'b1;
    store_model(a, d);
    model_locked = 1'b1;
    idle(1);
  endtask

  // p is creator, owner, isolation read, isolation write
  task automatic set_priv(input logic [3:0] p);
    @(posedge clk);
    req <= 1'b0;
    creator_priv <= p[3];
    owner_priv <= p[2];
    iso_rd_en <= p[1];
    iso_wr_en <= p[0];
    idle(3);
  endtask

  // done is due on the third falling edge after the driving edge
  task automatic issue_req(input flash_op_e op_v, input page_addr_t a, input flash_resp_t want);
    @(posedge clk);
    req <= 1'b1;
    req_data <= {op_v, a};
    cfg_we <= 1'b0;
    lock_set <= 1'b0;
    exp_q.push_back(want);
    due_q.push_back(neg_cnt + 3);
  endtask

  // outputs are compared in the middle of the cycle
  always @(negedge clk) begin
    flash_resp_t want;
    int due;
    neg_cnt = neg_cnt + 1;
    // the counter moves on the edge that ends the done pulse
    check("denial counter", {24'd0, deny_cnt}, {24'd0, model_deny});
    if (done) begin
      if (exp_q.size() == 0) begin
        abort_run("done pulse arrived while no request was in flight");
      end else begin
        want = exp_q.pop_front();
        due = due_q.pop_front();
        check("done falling edge index", neg_cnt, due);
        check("response granted_scramble_ecc_he", {28'd0, resp}, {28'd0, want});
        if (!want.granted && model_deny != 8'hff) begin
          model_deny = model_deny + 8'd1;
        end
      end
    end else if (due_q.size() != 0 && due_q[0] <= neg_cnt) begin
      abort_run("a request got no done pulse two cycles after it was sampled");
    end
  end

  initial begin
    #(watchdog_ns);
    abort_run("watchdog expired before the test sequence finished");
  end

  initial begin
    logic [31:0] rnd;
    flash_op_e op_v;
    page_addr_t a_v;
    void'($urandom(53721));
    repeat (2) @(posedge clk);
    arst_n <= 1'b1;
    idle(2);

    // fixed page setup used by the table
    write_cfg(4'b0_0_00, encode_cfg(7'b1101101));
    write_cfg(4'b0_0_01, encode_cfg(7'b1111111));
    write_cfg(4'b0_0_10, encode_cfg(7'b1110010));
    write_cfg(4'b0_0_11, encode_cfg(7'b1110100));
    write_cfg(4'b1_1_01, encode_cfg(7'b1010010));
    write_cfg(4'b0_1_00, encode_cfg(7'b0111111));
    write_cfg(4'b1_1_10, encode_cfg(7'b1111111));
    write_cfg(4'b1_1_11, encode_cfg(7'b1111111));

    for (int i = 0; i < table_len; i++) begin
      if (vec_tbl[i].priv != {creator_priv, owner_priv, iso_rd_en, iso_wr_en}) begin
        set_priv(vec_tbl[i].priv);
      end
      issue_req(vec_tbl[i].op, vec_tbl[i].addr, vec_tbl[i].want);
    end
    idle(4);

    // mixed random privileges, writes and back to back requests
    for (int n = 0; n < sweep_len; n++) begin
      rnd = $urandom;
      if (rnd[3:0] == 4'd0) begin
        set_priv(rnd[7:4]);
      end else if (rnd[3:0] == 4'd1) begin
        write_cfg(rnd[11:8], random_cfg());
      end else begin
        op_v = pick_op(rnd[13:12]);
        a_v = rnd[19:16];
        issue_req(op_v, a_v, predict(op_v, a_v));
      end
    end
    idle(4);

    // the unit comes out of reset unlocked and stays so until the lock request
    check("lock state before the lock", {31'd0, locked}, 32'd0);

    // a write after the lock must leave the page as it was
    lock_with_write(4'b1_0_00, encode_cfg(7'b1111111));
    write_cfg(4'b1_0_00, cfg_info_disable);
    issue_req(flash_op_read, 4'b1_0_00, 4'b1111);
    issue_req(flash_op_erase, 4'b1_0_00, predict(flash_op_erase, 4'b1_0_00));
    idle(4);
    check("lock state", {31'd0, locked}, 32'd1);

    // enough denials on a missing page to run the counter into saturation
    repeat (sat_len) begin
      issue_req(flash_op_read, 4'b1_1_11, predict(flash_op_read, 4'b1_1_11));
    end
    idle(4);
    check("saturated denial counter", {24'd0, deny_cnt}, 32'd255);
    check("lock state", {31'd0, locked}, 32'd1);

    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

// File: hw/flash_prot_top.sv
// info page protection unit
// requests are single-cycle strobes, results are single-cycle pulses 2 cycles later
// privilege inputs act on seed pages one cycle after they are sampled
// there is no bus interface, configuration is written through a plain strobe

`default_nettype none

`include "flash_prot_macros.svh"

module flash_prot_top import flash_prot_pkg::*; (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic cfg_we_i,
  input  page_addr_t cfg_addr_i,
  input  info_page_cfg_t cfg_wdata_i,
  input  logic lock_set_i,
  input  logic creator_seed_priv_i,
  input  logic owner_seed_priv_i,
  input  logic iso_flash_rd_en_i,
  input  logic iso_flash_wr_en_i,
  input  logic req_i,
  input  flash_req_t req_data_i,
  output logic done_o,
  output flash_resp_t resp_o,
  output logic locked_o,
  output logic [7:0] deny_cnt_o
);

  logic s1_en;
  logic s2_en;
  logic cfg_we;
  logic granted;
  info_cfg_array_t [`FLASH_BANKS-1:0][`FLASH_INFO_TYPES-1:0] cfgs_raw;
  info_cfg_array_t [`FLASH_BANKS-1:0][`FLASH_INFO_TYPES-1:0] cfgs_qual;

  flash_prot_ctrl u_ctrl (
    .clk_i,
    .arst_n_i,
    .req_i,
    .cfg_we_i,
    .lock_set_i,
    .granted_i(granted),
    .s1_en_o(s1_en),
    .s2_en_o(s2_en),
    .cfg_we_o(cfg_we),
    .done_o,
    .locked_o,
    .deny_cnt_o
  );

  flash_page_cfg_regs u_regs (
    .clk_i,
    .arst_n_i,
    .we_i(cfg_we),
    .addr_i(cfg_addr_i),
    .wdata_i(cfg_wdata_i),
    .cfgs_o(cfgs_raw)
  );

  // one qualifier per bank and partition type
  for (genvar b = 0; b < `FLASH_BANKS; b++) begin : gen_bank
    for (genvar t = 0; t < `FLASH_INFO_TYPES; t++) begin : gen_type
      flash_info_cfg #(
        .Bank(b),
        .InfoSel(t)
      ) u_info_cfg (
        .clk_i,
        .arst_n_i,
        .cfgs_i(cfgs_raw[b][t]),
        .creator_seed_priv_i,
        .owner_seed_priv_i,
        .iso_flash_wr_en_i,
        .iso_flash_rd_en_i,
        .cfgs_o(cfgs_qual[b][t])
      );
    end
  end

  flash_access_check u_check (
    .clk_i,
    .arst_n_i,
    .s1_en_i(s1_en),
    .s2_en_i(s2_en),
    .req_i(req_data_i),
    .cfgs_i(cfgs_qual),
    .resp_o,
    .granted_o(granted)
  );

endmodule

`default_nettype wire

// File: hw/flash_prot_ctrl.sv
// pipeline tracking, configuration lock and denial counter
// latency is fixed at 2 cycles from request strobe to done pulse
// the lock is sticky until reset, a write in the same cycle as the lock still goes in
// the denial counter saturates at 255

`default_nettype none

module flash_prot_ctrl (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic req_i,
  input  logic cfg_we_i,
  input  logic lock_set_i,
  input  logic granted_i,
  output logic s1_en_o,
  output logic s2_en_o,
  output logic cfg_we_o,
  output logic done_o,
  output logic locked_o,
  output logic [7:0] deny_cnt_o
);

  logic s1_valid_q;
  logic s2_valid_q;
  logic locked_q;
  logic [7:0] deny_cnt_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
      locked_q <= 1'b0;
      deny_cnt_q <= 8'd0;
    end else begin
      // a valid bit follows each request down the two stages
      s1_valid_q <= req_i;
      s2_valid_q <= s1_valid_q;
      locked_q <= locked_q | lock_set_i;
      // count while the done pulse is out with a denied result
      if (s2_valid_q && !granted_i && deny_cnt_q != 8'hff) begin
        deny_cnt_q <= deny_cnt_q + 8'd1;
      end
    end
  end

  // stage 1 loads on the request edge itself, stage 2 one edge later
  assign s1_en_o = req_i;
  assign s2_en_o = s1_valid_q;
  assign done_o = s2_valid_q;

  // only the registered lock gates writes, so a same-cycle lock lets the write through
  assign cfg_we_o = cfg_we_i & ~locked_q;
  assign locked_o = locked_q;
  assign deny_cnt_o = deny_cnt_q;

  a_lock_sticky: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    locked_o |=> locked_o);

  // every done pulse belongs to a request two edges back
  a_done_latency: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    done_o |-> $past(req_i, 2));

endmodule

`default_nettype wire

// File: hw/flash_access_check.sv
// two-stage permission check of one request against the qualified configs
// stage 1 captures the request and its page config, stage 2 forms the response
// stage enables come from the control block, there is no stall

`default_nettype none

`include "flash_prot_macros.svh"

module flash_access_check import flash_mubi_pkg::*; import flash_prot_pkg::*; (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic s1_en_i,
  input  logic s2_en_i,
  input  flash_req_t req_i,
  input  info_cfg_array_t [`FLASH_BANKS-1:0][`FLASH_INFO_TYPES-1:0] cfgs_i,
  output flash_resp_t resp_o,
  output logic granted_o
);

  flash_req_t req_q;
  info_page_cfg_t cfg_q;
  mubi4_t op_en;
  logic grant;
  flash_resp_t resp_d;
  flash_resp_t resp_q;

  // stage 1 takes the request and the addressed page's config on the request edge
  always_ff @(posedge clk_i) begin
    if (s1_en_i) begin
      req_q <= req_i;
      cfg_q <= cfgs_i[req_i.addr.bank][req_i.addr.info_sel][req_i.addr.page];
    end
  end

  // pick the access field that matches the operation
  always_comb begin
    case (req_q.op)
      flash_op_read: op_en = cfg_q.rd_en;
      flash_op_prog: op_en = cfg_q.prog_en;
      flash_op_erase: op_en = cfg_q.erase_en;
      default: op_en = mubi4_false;
    endcase
  end

  assign grant = mubi4_test_true(mubi4_and(cfg_q.en, op_en));

  // attributes are only revealed for a granted access
  assign resp_d = '{
    granted: grant,
    scramble: grant & mubi4_test_true(cfg_q.scramble_en),
    ecc: grant & mubi4_test_true(cfg_q.ecc_en),
    he: grant & mubi4_test_true(cfg_q.he_en)
  };

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      resp_q <= '0;
    end else if (s2_en_i) begin
      resp_q <= resp_d;
    end
  end

  assign resp_o = resp_q;
  assign granted_o = resp_q.granted;

  // a page that was not enabled when it reached stage 1 must come out denied
  a_grant_needs_en: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    s2_en_i && !mubi4_test_true(cfg_q.en) |=> !resp_q.granted);

endmodule

`default_nettype wire

// File: hw/flash_info_cfg.sv
// privilege qualification for the info pages of one bank and partition type
// seed privileges are registered once, so a change shows up one edge later
// isolation enables are used combinationally
// in instances that hold no seed pages the qualifiers are built but not used

`default_nettype none

`include "flash_prot_macros.svh"

module flash_info_cfg import flash_mubi_pkg::*; import flash_prot_pkg::*; #(
  parameter int unsigned Bank = 0,
  parameter int unsigned InfoSel = 0
) (
  input  logic clk_i,
  input  logic arst_n_i,
  input  info_cfg_array_t cfgs_i,
  input  logic creator_seed_priv_i,
  input  logic owner_seed_priv_i,
  input  logic iso_flash_wr_en_i,
  input  logic iso_flash_rd_en_i,
  output info_cfg_array_t cfgs_o
);

  // pages that exist in this partition type
  localparam int unsigned type_size =
    (InfoSel == 0) ? `FLASH_INFO_TYPE0_SIZE : `FLASH_INFO_TYPE1_SIZE;

  // true when this instance covers the seed and isolated pages
  localparam bit seed_here = (Bank == `FLASH_SEED_BANK) && (InfoSel == `FLASH_SEED_INFO_SEL);

  mubi4_t creator_en_q;
  mubi4_t owner_en_q;
  info_page_cfg_t creator_seed_qual;
  info_page_cfg_t owner_seed_qual;
  info_page_cfg_t isolate_qual;

  // privileges held as multi-bit values, false until the first edge after reset
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      creator_en_q <= mubi4_false;
      owner_en_q <= mubi4_false;
    end else begin
      creator_en_q <= mubi4_bool_to_mubi(creator_seed_priv_i);
      owner_en_q <= mubi4_bool_to_mubi(owner_seed_priv_i);
    end
  end

  // seed pages open all access fields together with their privilege
  // attributes are left as software configured them
  assign creator_seed_qual = '{
    en: creator_en_q,
    rd_en: creator_en_q,
    prog_en: creator_en_q,
    erase_en: creator_en_q,
    scramble_en: mubi4_true,
    ecc_en: mubi4_true,
    he_en: mubi4_true
  };

  assign owner_seed_qual = '{
    en: owner_en_q,
    rd_en: owner_en_q,
    prog_en: owner_en_q,
    erase_en: owner_en_q,
    scramble_en: mubi4_true,
    ecc_en: mubi4_true,
    he_en: mubi4_true
  };

  // the isolated page stays enabled, read and write follow the isolation enables
  assign isolate_qual = '{
    en: mubi4_true,
    rd_en: mubi4_bool_to_mubi(iso_flash_rd_en_i),
    prog_en: mubi4_bool_to_mubi(iso_flash_wr_en_i),
    erase_en: mubi4_bool_to_mubi(iso_flash_wr_en_i),
    scramble_en: mubi4_true,
    ecc_en: mubi4_true,
    he_en: mubi4_true
  };

  for (genvar i = 0; i < `FLASH_INFOS_PER_BANK; i++) begin : gen_page
    if (i >= type_size) begin : gen_disabled
      assign cfgs_o[i] = cfg_info_disable;
      // the slot may hold all-true software data, what leaves here must not
      a_nonexistent_off: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !mubi4_test_true(cfgs_o[i].en) && !mubi4_test_true(cfgs_o[i].rd_en) &&
        !mubi4_test_true(cfgs_o[i].prog_en) && !mubi4_test_true(cfgs_o[i].erase_en));
    end else if (seed_here && i == `FLASH_CREATOR_PAGE) begin : gen_creator
      assign cfgs_o[i] = info_cfg_qual(cfgs_i[i], creator_seed_qual);
    end else if (seed_here && i == `FLASH_OWNER_PAGE) begin : gen_owner
      assign cfgs_o[i] = info_cfg_qual(cfgs_i[i], owner_seed_qual);
    end else if (seed_here && i == `FLASH_ISOLATED_PAGE) begin : gen_isolated
      assign cfgs_o[i] = info_cfg_qual(cfgs_i[i], isolate_qual);
    end else begin : gen_normal
      // ordinary pages keep the software configuration
      assign cfgs_o[i] = cfgs_i[i];
    end
  end

endmodule

`default_nettype wire

// File: hw/flash_page_cfg_regs.sv
// software written storage for every info page configuration
// writes are already gated by the lock before they reach this block
// slots above a partition type's size are stored too, qualification drops them later

`default_nettype none

`include "flash_prot_macros.svh"

module flash_page_cfg_regs import flash_prot_pkg::*; (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic we_i,
  input  page_addr_t addr_i,
  input  info_page_cfg_t wdata_i,
  output info_cfg_array_t [`FLASH_BANKS-1:0][`FLASH_INFO_TYPES-1:0] cfgs_o
);

  info_cfg_array_t [`FLASH_BANKS-1:0][`FLASH_INFO_TYPES-1:0] cfg_q;

  // one register per page, all of them start out disabled
  // the addressed page takes the write data, the rest hold
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int b = 0; b < `FLASH_BANKS; b++) begin
        for (int t = 0; t < `FLASH_INFO_TYPES; t++) begin
          for (int p = 0; p < `FLASH_INFOS_PER_BANK; p++) begin
            cfg_q[b][t][p] <= cfg_info_disable;
          end
        end
      end
    end else if (we_i) begin
      cfg_q[addr_i.bank][addr_i.info_sel][addr_i.page] <= wdata_i;
    end
  end

  // new values are visible right after the write edge
  assign cfgs_o = cfg_q;

  // a write must land on a slot that exists in the geometry
  // this matters once a count stops being a power of two
  a_wr_in_geometry: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    we_i |-> (int'(addr_i.bank) < `FLASH_BANKS) &&
             (int'(addr_i.info_sel) < `FLASH_INFO_TYPES) &&
             (int'(addr_i.page) < `FLASH_INFOS_PER_BANK));

endmodule

`default_nettype wire

// File: hw/flash_prot_pkg.sv
// types shared by the info page protection unit
// address field widths follow from the geometry macros
// only info partitions exist here, there are no data partitions or region configs

`default_nettype none

`include "flash_prot_macros.svh"

package flash_prot_pkg;

  import flash_mubi_pkg::*;

  parameter int unsigned flash_bank_w = $clog2(`FLASH_BANKS);
  parameter int unsigned flash_info_sel_w = $clog2(`FLASH_INFO_TYPES);
  parameter int unsigned flash_page_w = $clog2(`FLASH_INFOS_PER_BANK);

  // permission and attribute set of one info page
  typedef struct packed {
    mubi4_t en;
    mubi4_t rd_en;
    mubi4_t prog_en;
    mubi4_t erase_en;
    mubi4_t scramble_en;
    mubi4_t ecc_en;
    mubi4_t he_en;
  } info_page_cfg_t;

  // every field false for reset and for pages that do not exist
  parameter info_page_cfg_t cfg_info_disable = '{
    en: mubi4_false,
    rd_en: mubi4_false,
    prog_en: mubi4_false,
    erase_en: mubi4_false,
    scramble_en: mubi4_false,
    ecc_en: mubi4_false,
    he_en: mubi4_false
  };

  // all page configurations of one bank and partition type
  typedef info_page_cfg_t [`FLASH_INFOS_PER_BANK-1:0] info_cfg_array_t;

  typedef struct packed {
    logic [flash_bank_w-1:0] bank;
    logic [flash_info_sel_w-1:0] info_sel;
    logic [flash_page_w-1:0] page;
  } page_addr_t;

  typedef enum logic [1:0] {
    flash_op_read = 2'd0,
    flash_op_prog = 2'd1,
    flash_op_erase = 2'd2
  } flash_op_e;

  typedef struct packed {
    flash_op_e op;
    page_addr_t addr;
  } flash_req_t;

  // attributes are plain bits and read as zero on a denied access
  typedef struct packed {
    logic granted;
    logic scramble;
    logic ecc;
    logic he;
  } flash_resp_t;

  // field by field conjunction of a software config with a qualifier
  function automatic info_page_cfg_t info_cfg_qual(input info_page_cfg_t cfg,
                                                   input info_page_cfg_t qual);
    info_page_cfg_t res;
    res.en = mubi4_and(cfg.en, qual.en);
    res.rd_en = mubi4_and(cfg.rd_en, qual.rd_en);
    res.prog_en = mubi4_and(cfg.prog_en, qual.prog_en);
    res.erase_en = mubi4_and(cfg.erase_en, qual.erase_en);
    res.scramble_en = mubi4_and(cfg.scramble_en, qual.scramble_en);
    res.ecc_en = mubi4_and(cfg.ecc_en, qual.ecc_en);
    res.he_en = mubi4_and(cfg.he_en, qual.he_en);
    return res;
  endfunction

endpackage

`default_nettype wire

// File: hw/flash_mubi_pkg.sv
// 4-bit multi-bit boolean type and helpers
// only the exact true encoding counts as true, every other value reads as false
// no integrity error is raised for values that are neither true nor false

`default_nettype none

package flash_mubi_pkg;

  typedef logic [3:0] mubi4_t;

  // encodings are complements of each other so that no single bit flip turns one into the other
  parameter mubi4_t mubi4_true = 4'h6;
  parameter mubi4_t mubi4_false = 4'h9;

  // plain bit to multi-bit encoding
  function automatic mubi4_t mubi4_bool_to_mubi(input logic val);
    return val ? mubi4_true : mubi4_false;
  endfunction

  // true only for the exact true encoding
  function automatic logic mubi4_test_true(input mubi4_t val);
    return val == mubi4_true;
  endfunction

  // any invalid operand makes the conjunction false
  function automatic mubi4_t mubi4_and(input mubi4_t a, input mubi4_t b);
    return (mubi4_test_true(a) && mubi4_test_true(b)) ? mubi4_true : mubi4_false;
  endfunction

endpackage

`default_nettype wire

// File: hw/flash_prot_macros.svh
// geometry and special page locations of the info partitions
// bank and partition counts must stay powers of two, because the address fields
// are sized with $clog2 and every encoding is assumed to be a real location
// the seed pages and the isolated page must all lie in one bank and partition type

`ifndef FLASH_PROT_MACROS_SVH
`define FLASH_PROT_MACROS_SVH

// number of banks, info partition types and info page slots per bank
`define FLASH_BANKS 2
`define FLASH_INFO_TYPES 2
`define FLASH_INFOS_PER_BANK 4

// pages that physically exist in each partition type
// slots above these sizes are always disabled
`define FLASH_INFO_TYPE0_SIZE 4
`define FLASH_INFO_TYPE1_SIZE 2

// bank and partition type that hold the seed pages and the isolated page
`define FLASH_SEED_BANK 0
`define FLASH_SEED_INFO_SEL 0

// page indices inside the seed bank and partition type
`define FLASH_CREATOR_PAGE 1
`define FLASH_OWNER_PAGE 2
`define FLASH_ISOLATED_PAGE 3

`endif
